/* Makefile */
VERILATOR ?= verilator
TOP       ?= card_glue_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/card_glue_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module card_glue_properties
    import a2_bus_pkg::*;
(
    input wire          clk_logic_w,
    input wire          arst,
    input card_resp_t   serial_i,
    input card_resp_t   sprite_i,
    input card_resp_t   sound_i,
    input logic         d_dir_i,
    input logic         irq_n_i,
    input logic         sys_rst_n_i,
    input bus_strobes_t strobes_i
);

    int         fail_cnt = 0;   // Property failures seen so far
    logic [5:0] pulses_w;

    assign pulses_w = {strobes_i.phi1.rise, strobes_i.phi1.fall, strobes_i.q3.rise,
                       strobes_i.q3.fall, strobes_i.m7.rise, strobes_i.m7.fall};

    // Bus driven toward the Apple II only when some card reads
    dir_needs_read: assert property (@(posedge clk_logic_w) disable iff (arst)
        d_dir_i |-> (serial_i.rd | sprite_i.rd | sound_i.rd))
    else begin
        $error("data direction high with no card read enable");
        fail_cnt++;
    end

    pulse_one_cycle: assert property (@(posedge clk_logic_w) disable iff (arst)
        (pulses_w & $past(pulses_w)) == 6'b0)
    else begin
        $error("strobe edge pulse held for more than one cycle");
        fail_cnt++;
    end

    irq_quiet_in_reset: assert property (@(posedge clk_logic_w) disable iff (arst)
        !sys_rst_n_i |-> irq_n_i)
    else begin
        $error("bus interrupt asserted while system reset active");
        fail_cnt++;
    end

endmodule

bind a2_card_glue card_glue_properties u_props (
    .clk_logic_w (clk_logic_w),
    .arst        (arst),
    .serial_i    (serial_i),
    .sprite_i    (sprite_i),
    .sound_i     (sound_i),
    .d_dir_i     (a2_d_dir_o),
    .irq_n_i     (a2_irq_n_o),
    .sys_rst_n_i (sys_rst_n_w),
    .strobes_i   (strobes_w)
);

`default_nettype wire

/* dv/card_glue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module card_glue_tb
    import a2_bus_pkg::*, a2_av_pkg::*;
();

    localparam int TRACE_ROWS  = 12;
    localparam int TRACE_COLS  = 18;
    localparam int TRACE_WORDS = TRACE_ROWS * TRACE_COLS;
    localparam int WAIT_LIMIT  = 200;   // Cycles any single wait may take
    localparam int TEST_RESET  = 0;
    localparam int TEST_ARB    = 1;
    localparam int TEST_AUDIO  = 2;
    localparam int TEST_SCAN   = 3;
    localparam int TEST_HB     = 4;
    localparam int TEST_ACT    = 5;

    logic        clk_logic_w;
    logic        arst;
    logic        a2_phi1_i;
    logic        a2_q3_i;
    logic        a2_7m_i;
    logic        a2_reset_n_i;
    card_resp_t  serial_i;
    card_resp_t  sprite_i;
    card_resp_t  sound_i;
    audio_src_t  audio_src_i;
    logic [3:0]  dip_n_i;
    logic        row_odd_i;
    rgb_t        pix_i;
    logic [7:0]  a2_d_o;
    logic        a2_d_dir_o;
    logic        a2_irq_n_o;
    stereo_t     audio_o;
    rgb_t        pix_o;
    logic [2:0]  led_o;
    logic        device_rst_n_o;
    logic        sys_rst_n_o;

    logic [31:0] trace_mem [TRACE_WORDS];
    int          errs [6];
    logic [15:0] lfsr_q = 16'd32769;

    tb_clock #(.PERIOD_NS(20.0)) u_clock (.clk_o(clk_logic_w));

    a2_card_glue #(.HEARTBEAT_TICKS(40)) dut (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_value(input int test, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errs[test]++;
        end
    endtask

    task automatic note_failure(input int test, input string msg);
        $display("%s", msg);
        errs[test]++;
    endtask

    task automatic test_done(input int test, input string name);
        $display("test %-14s %s, %0d errors", name, (errs[test] == 0) ? "ok" : "failed",
                 errs[test]);
    endtask

    // Trace columns hold the rd mask, three data bytes, the irq_n mask and the AV inputs
    task automatic apply_row(input int b);
        logic [2:0] rd;
        logic [2:0] irq;
        rd  = trace_mem[b][2:0];
        irq = trace_mem[b+4][2:0];
        serial_i    <= {rd[2], trace_mem[b+1][7:0], irq[2]};
        sprite_i    <= {rd[1], trace_mem[b+2][7:0], irq[1]};
        sound_i     <= {rd[0], trace_mem[b+3][7:0], irq[0]};
        audio_src_i <= {trace_mem[b+5][0], trace_mem[b+6][9:0],
                        trace_mem[b+7][9:0], trace_mem[b+8][9:0]};
        dip_n_i     <= trace_mem[b+9][3:0];
        row_odd_i   <= trace_mem[b+10][0];
        pix_i       <= trace_mem[b+11][23:0];
    endtask

    // Gap of 1 to 4 cycles from two LFSR bits
    task automatic toggle_phi1();
        int gap;
        gap = 1;
        for (int k = 0; k < 2; k++) begin
            if (lfsr_q[15]) gap = gap + (1 << k);
            lfsr_q = lfsr_next(lfsr_q);
        end
        repeat (gap) @(posedge clk_logic_w);
        a2_phi1_i <= ~a2_phi1_i;
    endtask

    // Counts negedges until the heartbeat changes or gives -1 on timeout
    task automatic cycles_to_heartbeat(output int n);
        logic start;
        start = led_o[0];
        n = 0;
        do begin
            @(negedge clk_logic_w);
            n++;
        end while (led_o[0] == start && n < WAIT_LIMIT);
        if (led_o[0] == start) n = -1;
    endtask

    initial begin
        int edges;
        int base;
        int n;
        int failed;
        int total;

        arst         = 1'b1;
        a2_phi1_i    = 1'b0;
        a2_q3_i      = 1'b0;
        a2_7m_i      = 1'b0;
        a2_reset_n_i = 1'b1;
        serial_i     = {1'b0, 8'h00, 1'b1};
        sprite_i     = {1'b0, 8'h00, 1'b1};
        sound_i      = {1'b0, 8'h00, 1'b1};
        audio_src_i  = '0;
        dip_n_i      = 4'hF;   // All switches off
        row_odd_i    = 1'b0;
        pix_i        = '0;
        for (int i = 0; i < TRACE_WORDS; i++) trace_mem[i] = 32'hBAD0_0000 | i;
        $readmemh("dv/card_glue_trace.txt", trace_mem);

        // ====================================================================
        // Reset release
        // ====================================================================
        repeat (2) @(posedge clk_logic_w);
        arst <= 1'b0;
        edges = 0;
        while (edges < WAIT_LIMIT) begin
            @(posedge clk_logic_w);
            edges++;
            @(negedge clk_logic_w);
            if (device_rst_n_o) break;
        end
        assert (device_rst_n_o) else note_failure(TEST_RESET, "device reset was never released");
        if (device_rst_n_o) check_value(TEST_RESET, "device_rst_n_o edges", edges, 101);
        check_value(TEST_RESET, "sys_rst_n_o", 32'(sys_rst_n_o), 0);
        @(negedge clk_logic_w);
        check_value(TEST_RESET, "sys_rst_n_o", 32'(sys_rst_n_o), 1);
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b0;
        @(negedge clk_logic_w);
        check_value(TEST_RESET, "sys_rst_n_o", 32'(sys_rst_n_o), 1);
        @(negedge clk_logic_w);
        check_value(TEST_RESET, "sys_rst_n_o", 32'(sys_rst_n_o), 0);
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b1;
        @(negedge clk_logic_w);
        check_value(TEST_RESET, "sys_rst_n_o", 32'(sys_rst_n_o), 0);
        @(negedge clk_logic_w);
        check_value(TEST_RESET, "sys_rst_n_o", 32'(sys_rst_n_o), 1);
        test_done(TEST_RESET, "reset_release");

        // ====================================================================
        // Trace rows with the arbiter in the same cycle and the mixer one later
        // ====================================================================
        assert (trace_mem[TRACE_WORDS-1] != (32'hBAD0_0000 | (TRACE_WORDS-1)))
            else note_failure(TEST_ARB, "trace file dv/card_glue_trace.txt could not be read");
        for (int r = 0; r < TRACE_ROWS; r++) begin
            base = r * TRACE_COLS;
            @(posedge clk_logic_w);
            apply_row(base);
            @(negedge clk_logic_w);
            check_value(TEST_ARB, $sformatf("a2_d_o row %0d", r), 32'(a2_d_o),
                        trace_mem[base+12]);
            check_value(TEST_ARB, $sformatf("a2_d_dir_o row %0d", r), 32'(a2_d_dir_o),
                        trace_mem[base+13]);
            check_value(TEST_ARB, $sformatf("a2_irq_n_o row %0d", r), 32'(a2_irq_n_o),
                        trace_mem[base+14]);
            @(negedge clk_logic_w);
            check_value(TEST_AUDIO, $sformatf("audio_o.left row %0d", r), 32'(audio_o.left),
                        trace_mem[base+15]);
            check_value(TEST_AUDIO, $sformatf("audio_o.right row %0d", r), 32'(audio_o.right),
                        trace_mem[base+16]);
            check_value(TEST_SCAN, $sformatf("pix_o row %0d", r), 32'(pix_o),
                        trace_mem[base+17]);
        end
        test_done(TEST_ARB, "arbitration");
        test_done(TEST_AUDIO, "audio");
        test_done(TEST_SCAN, "scanlines");

        // The first heartbeat toggle only aligns
        cycles_to_heartbeat(n);
        assert (n >= 0) else note_failure(TEST_HB, "heartbeat indicator never toggled");
        for (int k = 0; k < 2; k++) begin
            cycles_to_heartbeat(n);
            assert (n >= 0) else note_failure(TEST_HB, "heartbeat indicator stopped toggling");
            if (n >= 0) check_value(TEST_HB, "heartbeat period", n, 40);
        end
        test_done(TEST_HB, "heartbeat");

        // ====================================================================
        // phi1 activity indicator
        // ====================================================================
        toggle_phi1();                          // Rising edge 1
        for (int e = 1; e < 1023; e++) begin
            toggle_phi1();
            toggle_phi1();
        end
        // Counter one short of the top bit while phi1 sits high
        repeat (WAIT_LIMIT) @(negedge clk_logic_w);
        check_value(TEST_ACT, "led_o[1] held high after 1023 edges", 32'(led_o[1]), 0);
        toggle_phi1();                          // Falling edge
        repeat (8) @(negedge clk_logic_w);
        check_value(TEST_ACT, "led_o[1] after falling edge", 32'(led_o[1]), 0);
        toggle_phi1();                          // Rising edge 1024
        n = 0;
        while (!led_o[1] && n < 10) begin
            @(negedge clk_logic_w);
            n++;
        end
        assert (led_o[1])
            else note_failure(TEST_ACT, "phi1 indicator did not set after 1024 edges");
        check_value(TEST_ACT, "led_o[2]", 32'(led_o[2]), 0);   // q3 never moved
        test_done(TEST_ACT, "activity");

        failed = 0;
        total  = 0;
        for (int t = 0; t < 6; t++) begin
            total += errs[t];
            if (errs[t] != 0) failed++;
        end
        assert (dut.u_props.fail_cnt == 0) else begin
            $display("bound properties failed %0d times", dut.u_props.fail_cnt);
            total += dut.u_props.fail_cnt;
        end
        $display("tests run: 6, tests failed: %0d, errors: %0d", failed, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/card_glue_trace.txt */
// rd ser spr snd irq | spk spa snl snr dip_n odd pix | exp: d dir irq left right pix
// rd and irq are masks with bit 2 serial, bit 1 sprite, bit 0 sound
0 00 00 00 7  0 000 000 000 F 0 000000  00 0 1 0000 0000 000000
4 5A 33 77 7  1 001 002 003 F 0 804020  5A 1 1 0018 0020 804020
3 5A 33 77 7  1 001 002 003 D 1 804020  33 1 1 1018 1020 804020
1 11 22 C3 6  1 3FF 3FF 000 C 1 FF8001  C3 1 0 4FF0 2FF8 7F4000
0 AA BB CC 3  0 100 200 080 E 0 123456  00 0 0 1800 0C00 123456
2 AA BB CC 5  1 100 200 080 E 1 123456  BB 1 0 1800 0C00 091A2B
7 01 02 03 7  1 000 000 000 C 1 FEFEFE  01 1 1 1000 1000 7F7F7F
6 9E 02 03 7  0 3FF 000 3FF C 0 ABCDEF  9E 1 1 1FF8 3FF0 ABCDEF
5 00 FF FF 4  1 155 2AA 0AA F 1 010203  00 1 0 1FF8 0FF8 010203
2 00 7E 00 7  1 080 040 3C0 D 1 7F7F7F  7E 1 1 1600 3200 7F7F7F
0 00 00 00 7  0 000 001 3FF E 1 808080  00 0 1 0008 1FF8 404040
1 00 00 80 7  1 3FF 3FF 3FF C 0 FFFFFF  80 1 1 4FF0 4FF0 FFFFFF

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // Free running, 50% duty

endmodule

`default_nettype wire

/* filelist.f */
rtl/a2_bus_pkg.sv
rtl/a2_av_pkg.sv
rtl/strobe_sync.sv
rtl/reset_seq.sv
rtl/activity_timer.sv
rtl/bus_arbiter.sv
rtl/av_mixer.sv
rtl/a2_card_glue.sv
dv/tb_clock.sv
dv/card_glue_properties.sv
dv/card_glue_tb.sv

/* rtl/a2_av_pkg.sv */
`default_nettype none

package a2_av_pkg;

    localparam int SAMPLE_W      = 16;
    localparam int SRC_SHIFT     = 3;   // 10-bit sources up to 13 bits
    localparam int SPEAKER_SHIFT = 12;  // Speaker sits on bit 12

    // Raw audio sources from the emulated cards
    typedef struct packed {
        logic       speaker;
        logic [9:0] sprite;
        logic [9:0] sound_l;
        logic [9:0] sound_r;
    } audio_src_t;

    // Mixed output sample pair
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } stereo_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

`default_nettype wire

/* rtl/a2_bus_pkg.sv */
`default_nettype none

package a2_bus_pkg;

    // ========================================================================
    // Card bus response and strobe types
    // ========================================================================

    // One card's read response, 10 bits
    typedef struct packed {
        logic       rd;     // Card drives the data bus
        logic [7:0] data;
        logic       irq_n;  // Active low
    } card_resp_t;

    // One synchronized bus strobe
    typedef struct packed {
        logic level;
        logic rise;   // One cycle pulse
        logic fall;   // One cycle pulse
    } strobe_t;

    typedef struct packed {
        strobe_t phi1;
        strobe_t q3;
        strobe_t m7;
    } bus_strobes_t;

    localparam int RESET_CYCLES   = 100;  // Device reset hold after arst
    localparam int ACTIVITY_BITS  = 11;   // Top bit drives the indicator
    localparam bit IRQ_OUT_ENABLE = 1'b1; // Allow driving the bus IRQ

endpackage

`default_nettype wire

/* rtl/a2_card_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module a2_card_glue
    import a2_bus_pkg::*, a2_av_pkg::*;
#(
    parameter int HEARTBEAT_TICKS = 10_000_000
) (
    input  wire        clk_logic_w,
    input  wire        arst,
    input  logic       a2_phi1_i,
    input  logic       a2_q3_i,
    input  logic       a2_7m_i,
    input  logic       a2_reset_n_i,
    input  card_resp_t serial_i,
    input  card_resp_t sprite_i,
    input  card_resp_t sound_i,
    input  audio_src_t audio_src_i,
    input  logic [3:0] dip_n_i,        // [0] scanline, [1] speaker, [3:2] spare
    input  logic       row_odd_i,
    input  rgb_t       pix_i,
    output logic [7:0] a2_d_o,
    output logic       a2_d_dir_o,
    output logic       a2_irq_n_o,
    output stereo_t    audio_o,
    output rgb_t       pix_o,
    output logic [2:0] led_o,
    output logic       device_rst_n_o,
    output logic       sys_rst_n_o
);

    bus_strobes_t strobes_w;
    logic         device_rst_n_w;
    logic         sys_rst_n_w;
    logic [7:0]   arb_data_w;
    logic         arb_dir_w;
    logic         arb_irq_n_w;
    logic         sw_scanline_w;
    logic         sw_speaker_w;

    assign sw_scanline_w = ~dip_n_i[0];   // Switches read low when on
    assign sw_speaker_w  = ~dip_n_i[1];

    // ========================================================================
    // Clocking and reset
    // ========================================================================
    strobe_sync u_strobe_sync (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .phi1_i      (a2_phi1_i),
        .q3_i        (a2_q3_i),
        .m7_i        (a2_7m_i),
        .strobes_o   (strobes_w)
    );

    reset_seq u_reset_seq (
        .clk_logic_w    (clk_logic_w),
        .arst           (arst),
        .a2_reset_n_i   (a2_reset_n_i),
        .device_rst_n_o (device_rst_n_w),
        .sys_rst_n_o    (sys_rst_n_w)
    );

    activity_timer #(
        .HEARTBEAT_TICKS (HEARTBEAT_TICKS)
    ) u_activity_timer (
        .clk_logic_w (clk_logic_w),
        .arst        (arst),
        .run_i       (device_rst_n_w),
        .strobes_i   (strobes_w),
        .led_o       (led_o)
    );

    // ========================================================================
    // Apple II bus side
    // ========================================================================
    bus_arbiter u_bus_arbiter (
        .serial_i (serial_i),
        .sprite_i (sprite_i),
        .sound_i  (sound_i),
        .data_o   (arb_data_w),
        .d_dir_o  (arb_dir_w),
        .irq_n_o  (arb_irq_n_w)
    );

    // Bus stays quiet while the system is held in reset
    assign a2_d_o     = sys_rst_n_w ? arb_data_w : 8'h00;
    assign a2_d_dir_o = sys_rst_n_w & arb_dir_w;
    assign a2_irq_n_o = ~sys_rst_n_w | arb_irq_n_w;

    // Mixer outputs stay zero until device reset lifts
    av_mixer u_av_mixer (
        .clk_logic_w   (clk_logic_w),
        .arst          (~device_rst_n_w),
        .src_i         (audio_src_i),
        .speaker_en_i  (sw_speaker_w),
        .scanline_en_i (sw_scanline_w),
        .row_odd_i     (row_odd_i),
        .pix_i         (pix_i),
        .audio_o       (audio_o),
        .pix_o         (pix_o)
    );

    assign device_rst_n_o = device_rst_n_w;
    assign sys_rst_n_o    = sys_rst_n_w;

endmodule

`default_nettype wire

/* rtl/activity_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module activity_timer
    import a2_bus_pkg::*;
#(
    parameter int HEARTBEAT_TICKS = 10_000_000
) (
    input  wire          clk_logic_w,
    input  wire          arst,
    input  logic         run_i,        // Device reset released
    input  bus_strobes_t strobes_i,
    output logic [2:0]   led_o         // [0] heartbeat, [1] phi1, [2] q3
);

    localparam int HB_W = $clog2(HEARTBEAT_TICKS + 1);
    localparam logic [HB_W-1:0] HB_LAST = HB_W'(HEARTBEAT_TICKS - 1);

    logic [HB_W-1:0]                   hb_cnt_q;
    logic                              hb_q;
    logic [1:0][ACTIVITY_BITS-1:0]     act_q;      // [0] phi1, [1] q3
    logic [1:0]                        step_w;

    assign step_w = {strobes_i.q3.rise, strobes_i.phi1.rise};

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            hb_cnt_q <= '0;
            hb_q     <= 1'b0;
            act_q    <= '0;
        end else if (!run_i) begin
            // Everything parked until the card leaves reset
            hb_cnt_q <= '0;
            hb_q     <= 1'b0;
            act_q    <= '0;
        end else begin
            if (hb_cnt_q == HB_LAST) begin
                hb_cnt_q <= '0;
                hb_q     <= ~hb_q;
            end else begin
                hb_cnt_q <= hb_cnt_q + 1'b1;
            end

            for (int i = 0; i < 2; i++) begin
                if (step_w[i]) begin
                    act_q[i] <= act_q[i] + 1'b1;   // Wraps freely
                end
            end
        end
    end

    assign led_o = {act_q[1][ACTIVITY_BITS-1], act_q[0][ACTIVITY_BITS-1], hb_q};

endmodule

`default_nettype wire

/* rtl/av_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module av_mixer
    import a2_av_pkg::*;
(
    input  wire        clk_logic_w,
    input  wire        arst,
    input  audio_src_t src_i,
    input  logic       speaker_en_i,
    input  logic       scanline_en_i,
    input  logic       row_odd_i,
    input  rgb_t       pix_i,
    output stereo_t    audio_o,
    output rgb_t       pix_o
);

    logic [SAMPLE_W-1:0] speaker_w;
    logic [SAMPLE_W-1:0] sprite_w;
    logic [SAMPLE_W-1:0] sound_l_w;
    logic [SAMPLE_W-1:0] sound_r_w;
    stereo_t             mix_w;
    logic                dim_w;
    rgb_t                pix_w;
    stereo_t             audio_q;
    rgb_t                pix_q;

    // ========================================================================
    // Audio, all sources unsigned and aligned to the 16-bit sample
    // ========================================================================
    assign speaker_w = SAMPLE_W'(src_i.speaker & speaker_en_i) << SPEAKER_SHIFT;
    assign sprite_w  = SAMPLE_W'(src_i.sprite) << SRC_SHIFT;
    assign sound_l_w = SAMPLE_W'(src_i.sound_l) << SRC_SHIFT;
    assign sound_r_w = SAMPLE_W'(src_i.sound_r) << SRC_SHIFT;

    assign mix_w.left  = speaker_w + sprite_w + sound_l_w;   // Carry out dropped
    assign mix_w.right = speaker_w + sprite_w + sound_r_w;

    // ========================================================================
    // Scanline dimming on odd rows
    // ========================================================================
    assign dim_w   = scanline_en_i & row_odd_i;
    assign pix_w.r = dim_w ? {1'b0, pix_i.r[7:1]} : pix_i.r;
    assign pix_w.g = dim_w ? {1'b0, pix_i.g[7:1]} : pix_i.g;
    assign pix_w.b = dim_w ? {1'b0, pix_i.b[7:1]} : pix_i.b;

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            audio_q <= '0;
            pix_q   <= '0;
        end else begin
            audio_q <= mix_w;
            pix_q   <= pix_w;
        end
    end

    assign audio_o = audio_q;
    assign pix_o   = pix_q;

endmodule

`default_nettype wire

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import a2_bus_pkg::*;
(
    input  card_resp_t serial_i,
    input  card_resp_t sprite_i,
    input  card_resp_t sound_i,
    output logic [7:0] data_o,
    output logic       d_dir_o,
    output logic       irq_n_o
);

    // Fixed priority, serial wins over sprite, sprite over sound
    always_comb begin
        if (serial_i.rd) begin
            data_o = serial_i.data;
        end else if (sprite_i.rd) begin
            data_o = sprite_i.data;
        end else if (sound_i.rd) begin
            data_o = sound_i.data;
        end else begin
            data_o = 8'h00;
        end
    end

    assign d_dir_o = serial_i.rd | sprite_i.rd | sound_i.rd; // Toward the Apple II

    // Wired-AND of the card interrupts
    assign irq_n_o = ~IRQ_OUT_ENABLE | (serial_i.irq_n & sprite_i.irq_n & sound_i.irq_n);

endmodule

`default_nettype wire

/* rtl/reset_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_seq
    import a2_bus_pkg::*;
(
    input  wire  clk_logic_w,
    input  wire  arst,
    input  logic a2_reset_n_i,
    output logic device_rst_n_o,
    output logic sys_rst_n_o
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESET_CYCLES - 1);

    typedef enum logic [1:0] {
        HOLD,
        COUNT,
        RUN
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             dev_rst_n_q;
    logic             sys_rst_n_q;

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            state_q     <= HOLD;
            cnt_q       <= '0;
            dev_rst_n_q <= 1'b0;
            sys_rst_n_q <= 1'b0;
        end else begin
            sys_rst_n_q <= dev_rst_n_q & a2_reset_n_i; // Bus reset joins here
            case (state_q)
                HOLD: begin
                    state_q <= COUNT;
                    cnt_q   <= '0;
                end
                COUNT: begin
                    if (cnt_q == CNT_LAST) begin
                        state_q     <= RUN;
                        dev_rst_n_q <= 1'b1;   // Edge RESET_CYCLES + 1
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RUN:     dev_rst_n_q <= 1'b1;
                default: state_q <= HOLD;
            endcase
        end
    end

    assign device_rst_n_o = dev_rst_n_q;
    assign sys_rst_n_o    = sys_rst_n_q;

endmodule

`default_nettype wire

/* rtl/strobe_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module strobe_sync
    import a2_bus_pkg::*;
(
    input  wire          clk_logic_w,
    input  wire          arst,
    input  logic         phi1_i,
    input  logic         q3_i,
    input  logic         m7_i,
    output bus_strobes_t strobes_o
);

    // Bit 0 phi1, bit 1 q3, bit 2 7M
    logic [2:0] sync1_q;
    logic [2:0] sync2_q;
    logic [2:0] level_q;
    logic [2:0] rise_q;
    logic [2:0] fall_q;

    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            sync1_q <= '0;
            sync2_q <= '0;
            level_q <= '0;
            rise_q  <= '0;
            fall_q  <= '0;
        end else begin
            sync1_q <= {m7_i, q3_i, phi1_i};   // Metastability stage
            sync2_q <= sync1_q;
            level_q <= sync2_q;
            // Edge pulses line up with the level change
            rise_q  <= sync2_q & ~level_q;
            fall_q  <= ~sync2_q & level_q;
        end
    end

    assign strobes_o.phi1 = {level_q[0], rise_q[0], fall_q[0]};
    assign strobes_o.q3   = {level_q[1], rise_q[1], fall_q[1]};
    assign strobes_o.m7   = {level_q[2], rise_q[2], fall_q[2]};

endmodule

`default_nettype wire
